//--- compile.f
+incdir+dv
source/rv_pkg.sv
source/rv_regfile.sv
source/rv_decode.sv
source/rv_execute.sv
source/rv_retire.sv
source/rv_core_top.sv
dv/tb_rv_core.sv

//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --assert -j 0
TOP       := tb_rv_core
RTL_TOP   := rv_core_top
FILELIST  := compile.f
RTL_SRCS  := $(shell grep '^source/' $(FILELIST))
LOG       := sim.log
PASS_MSG  := *** PASSED ***

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	./obj_dir/V$(TOP) | tee $(LOG)
	@grep -qF "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) --lint-only --top-module $(RTL_TOP) $(RTL_SRCS)
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir $(LOG)

//--- dv/rv_ref_model.svh
`ifndef RV_REF_MODEL_SVH
`define RV_REF_MODEL_SVH

// expected retirement, data only compared for supported words
typedef struct packed {
    rv_pkg::ex_wb_t res;
    logic           data_valid;
} expect_t;

function automatic rv_pkg::xlen_t enc_r(
    input logic [6:0]        f7,
    input logic [2:0]        f3,
    input rv_pkg::reg_addr_t rd,
    input rv_pkg::reg_addr_t rs1,
    input rv_pkg::reg_addr_t rs2
);
    return {f7, rs2, rs1, f3, rd, rv_pkg::OPC_OP};
endfunction

function automatic rv_pkg::xlen_t enc_i(
    input logic [11:0]       imm,
    input logic [2:0]        f3,
    input rv_pkg::reg_addr_t rd,
    input rv_pkg::reg_addr_t rs1
);
    return {imm, rs1, f3, rd, rv_pkg::OPC_OP_IMM};
endfunction

function automatic rv_pkg::xlen_t enc_u(
    input logic [19:0]       imm,
    input rv_pkg::reg_addr_t rd
);
    return {imm, rd, rv_pkg::OPC_LUI};
endfunction

// RV32I semantics of the kept subset
function automatic expect_t model_result(
    input rv_pkg::xlen_t inst,
    input rv_pkg::xlen_t rs1_val,
    input rv_pkg::xlen_t rs2_val
);
    expect_t       e;
    logic [6:0]    opc;
    logic [2:0]    f3;
    logic [6:0]    f7;
    rv_pkg::xlen_t b;
    logic          legal;
    opc   = inst[6:0];
    f3    = inst[14:12];
    f7    = inst[31:25];
    b     = (opc == rv_pkg::OPC_OP) ? rs2_val : {{20{inst[31]}}, inst[31:20]};
    legal = opc == rv_pkg::OPC_LUI || opc == rv_pkg::OPC_OP || opc == rv_pkg::OPC_OP_IMM;
    // only SUB and SRA may set funct7 bit 5
    if (opc == rv_pkg::OPC_OP)
        legal = f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));
    else if (opc == rv_pkg::OPC_OP_IMM && f3 == 3'd1)
        legal = f7 == 7'h00;
    else if (opc == rv_pkg::OPC_OP_IMM && f3 == 3'd5)
        legal = f7 == 7'h00 || f7 == 7'h20;
    case (f3)
        3'd0:    e.res.data = (opc == rv_pkg::OPC_OP && f7[5]) ? rs1_val - b : rs1_val + b;
        3'd1:    e.res.data = rs1_val << b[4:0];
        3'd2:    e.res.data = ($signed(rs1_val) < $signed(b)) ? 32'd1 : 32'd0;
        3'd3:    e.res.data = (rs1_val < b) ? 32'd1 : 32'd0;
        3'd4:    e.res.data = rs1_val ^ b;
        3'd5:    e.res.data = f7[5] ? rv_pkg::xlen_t'($signed(rs1_val) >>> b[4:0])
                                    : rs1_val >> b[4:0];
        3'd6:    e.res.data = rs1_val | b;
        default: e.res.data = rs1_val & b;
    endcase
    if (opc == rv_pkg::OPC_LUI)
        e.res.data = {inst[31:12], 12'h000};
    e.res.rd      = inst[11:7];
    e.res.wen     = legal && inst[11:7] != 5'd0;
    e.res.illegal = !legal;
    e.data_valid  = legal;
    return e;
endfunction

`endif

//--- dv/tb_rv_core.sv
module tb_rv_core;

    localparam int N_INST    = 400;
    localparam int DRIVE_DLY = 2;
    // ten clock periods per instruction
    localparam int TIMEOUT   = N_INST * 10 * 20;

    `include "rv_ref_model.svh"

    logic              clk = 1'b0;
    logic              rst_n;
    logic              inst_valid_i;
    rv_pkg::xlen_t     inst_i;
    logic              inst_allowin_o;
    logic              retire_valid_o;
    rv_pkg::ex_wb_t    retire_o;
    logic              retire_ready_i;

    rv_pkg::xlen_t     model_rf [0:31];
    expect_t           exp_q [$];
    expect_t           exp_head;
    int                exp_cnt;
    int                retired_cnt;
    rv_pkg::reg_addr_t recent [$];

    rv_core_top dut_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .inst_valid_i   (inst_valid_i),
        .inst_i         (inst_i),
        .inst_allowin_o (inst_allowin_o),
        .retire_valid_o (retire_valid_o),
        .retire_o       (retire_o),
        .retire_ready_i (retire_ready_i)
    );

    always #10 clk = ~clk;

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("*** FAILED ***");
        $fatal(1);
    endtask

    // mostly reuse recent destinations to get back-to-back dependencies
    function automatic rv_pkg::reg_addr_t pick_src();
        int unsigned idx;
        if (recent.size() == 0 || $urandom_range(0, 3) == 0)
            return rv_pkg::reg_addr_t'($urandom_range(0, 31));
        idx = $urandom_range(0, recent.size() - 1);
        return recent[idx];
    endfunction

    function automatic rv_pkg::xlen_t make_inst();
        rv_pkg::reg_addr_t rd;
        rv_pkg::reg_addr_t rs1;
        rv_pkg::reg_addr_t rs2;
        rv_pkg::xlen_t     word;
        logic [2:0]        f3;
        logic [11:0]       imm;
        logic              alt;
        int unsigned       kind;
        rd   = ($urandom_range(0, 15) == 0) ? 5'd0 : rv_pkg::reg_addr_t'($urandom_range(1, 12));
        rs1  = pick_src();
        rs2  = pick_src();
        f3   = 3'($urandom_range(0, 7));
        imm  = 12'($urandom());
        alt  = $urandom_range(0, 1) != 0;
        kind = $urandom_range(0, 19);
        if (kind < 9) begin
            alt  = alt && (f3 == 3'd0 || f3 == 3'd5);
            word = enc_r(alt ? 7'h20 : 7'h00, f3, rd, rs1, rs2);
        end else if (kind < 17) begin
            if (f3 == 3'd1)
                imm[11:5] = 7'h00;
            else if (f3 == 3'd5)
                imm[11:5] = alt ? 7'h20 : 7'h00;
            word = enc_i(imm, f3, rd, rs1);
        end else if (kind < 19) begin
            word = enc_u(20'($urandom()), rd);
        end else begin
            // load opcode, MUL, or SLLI with funct7 set
            case ($urandom_range(0, 2))
                0: begin
                    word      = $urandom();
                    word[6:0] = 7'b0000011;
                end
                1:       word = enc_r(7'h01, f3, rd, rs1, rs2);
                default: word = enc_i({7'h20, imm[4:0]}, 3'd1, rd, rs1);
            endcase
        end
        if (rd != 5'd0) begin
            recent.push_back(rd);
            if (recent.size() > 4)
                void'(recent.pop_front());
        end
        return word;
    endfunction

    task automatic send_inst(input rv_pkg::xlen_t word);
        logic taken;
        while ($urandom_range(0, 4) == 0) begin
            inst_valid_i = 1'b0;
            @(posedge clk);
            #DRIVE_DLY;
        end
        inst_valid_i = 1'b1;
        inst_i       = word;
        taken        = 1'b0;
        // allowin is settled by the falling edge
        while (!taken) begin
            @(negedge clk);
            taken = inst_allowin_o;
            @(posedge clk);
            #DRIVE_DLY;
        end
    endtask

    // hold off until every accepted instruction has retired
    task automatic wait_drained();
        inst_valid_i = 1'b0;
        do begin
            @(posedge clk);
            #DRIVE_DLY;
        end while (exp_q.size() != 0);
    endtask

    // model state moves in program order at accept time
    always @(posedge clk) begin
        expect_t e;
        if (!rst_n) begin
            foreach (model_rf[i])
                model_rf[i] = '0;
            exp_q.delete();
            exp_cnt     <= 0;
            retired_cnt = 0;
        end else begin
            if (retire_valid_o && retire_ready_i) begin
                if (exp_q.size() > 0)
                    void'(exp_q.pop_front());
                retired_cnt++;
            end
            if (inst_valid_i && inst_allowin_o) begin
                e = model_result(inst_i, model_rf[inst_i[19:15]], model_rf[inst_i[24:20]]);
                if (e.res.wen)
                    model_rf[e.res.rd] = e.res.data;
                exp_q.push_back(e);
            end
            exp_cnt <= exp_q.size();
            if (exp_q.size() > 0)
                exp_head <= exp_q[0];
        end
    end

    a_extra: assert property (@(posedge clk) disable iff (!rst_n)
        (retire_valid_o && retire_ready_i) |-> exp_cnt != 0)
        else report_failure($sformatf("ERROR at %0t: result retired with none pending", $time));

    a_result: assert property (@(posedge clk) disable iff (!rst_n)
        (retire_valid_o && retire_ready_i && exp_cnt != 0) |->
            (retire_o.rd == exp_head.res.rd && retire_o.wen == exp_head.res.wen
             && retire_o.illegal == exp_head.res.illegal
             && (!exp_head.data_valid || retire_o.data == exp_head.res.data)))
        else report_failure($sformatf("ERROR at %0t: retired result differs from model", $time));

    a_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (retire_valid_o && !retire_ready_i) |=> (retire_valid_o && $stable(retire_o)))
        else report_failure($sformatf("ERROR at %0t: stalled result changed", $time));

    a_no_write: assert property (@(posedge clk) disable iff (!rst_n)
        (retire_valid_o && (retire_o.rd == 5'd0 || retire_o.illegal)) |-> !retire_o.wen)
        else report_failure($sformatf("ERROR at %0t: write enable set for x0 or illegal", $time));

    // empty pipeline means nothing pending in the model
    a_latency: assert property (@(posedge clk) disable iff (!rst_n)
        (inst_valid_i && inst_allowin_o && retire_ready_i && exp_cnt == 0) |->
            ##1 !retire_valid_o ##1 !retire_valid_o ##1 retire_valid_o)
        else report_failure($sformatf("ERROR at %0t: retire latency is not three edges", $time));

    initial begin
        retire_ready_i = 1'b0;
        @(posedge rst_n);
        forever begin
            @(posedge clk);
            #DRIVE_DLY;
            retire_ready_i = $urandom_range(0, 3) != 0;
        end
    end

    initial begin
        #TIMEOUT;
        report_failure($sformatf("run timed out after %0d time units, %0d of %0d retired",
                                 TIMEOUT, retired_cnt, N_INST));
    end

    initial begin
        void'($urandom(32'h1db9));
        rst_n        = 1'b0;
        inst_valid_i = 1'b0;
        inst_i       = '0;
        repeat (16) @(posedge clk);
        #DRIVE_DLY;
        rst_n = 1'b1;
        assert (!retire_valid_o && inst_allowin_o)
            else report_failure($sformatf("ERROR at %0t: pipeline not idle after reset", $time));
        for (int i = 0; i < N_INST; i++) begin
            // let the pipeline empty now and then
            if (i % 25 == 24)
                wait_drained();
            send_inst(make_inst());
        end
        inst_valid_i = 1'b0;
        while (retired_cnt < N_INST)
            @(negedge clk);
        repeat (4) @(negedge clk);
        if (retired_cnt == N_INST && exp_q.size() == 0) begin
            $display("*** PASSED ***");
            $finish;
        end else begin
            report_failure("results were left pending or retired twice at the end of the run");
        end
    end

endmodule

//--- source/rv_core_top.sv
module rv_core_top (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           inst_valid_i,
    input  rv_pkg::xlen_t  inst_i,
    output logic           inst_allowin_o,
    output logic           retire_valid_o,
    output rv_pkg::ex_wb_t retire_o,
    input  logic           retire_ready_i
);

    logic              dec_valid;
    rv_pkg::id_ex_t    dec_out;
    logic              ex_allowin;
    logic              ex_valid;
    rv_pkg::ex_wb_t    ex_out;
    logic              wb_allowin;
    rv_pkg::reg_addr_t rf_raddr1;
    rv_pkg::reg_addr_t rf_raddr2;
    rv_pkg::xlen_t     rf_rdata1;
    rv_pkg::xlen_t     rf_rdata2;
    logic              rf_wen;
    rv_pkg::reg_addr_t rf_waddr;
    rv_pkg::xlen_t     rf_wdata;

    rv_decode decode_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .inst_valid_i   (inst_valid_i),
        .inst_i         (inst_i),
        .inst_allowin_o (inst_allowin_o),
        .ex_allowin_i   (ex_allowin),
        .dec_valid_o    (dec_valid),
        .dec_o          (dec_out),
        .rf_raddr1_o    (rf_raddr1),
        .rf_raddr2_o    (rf_raddr2),
        .rf_rdata1_i    (rf_rdata1),
        .rf_rdata2_i    (rf_rdata2),
        // execute result first, then the held retire result
        .ex_fwd_valid_i (ex_valid),
        .ex_fwd_i       (ex_out),
        .wb_fwd_valid_i (retire_valid_o),
        .wb_fwd_i       (retire_o)
    );

    rv_regfile regfile_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .raddr1_i (rf_raddr1),
        .raddr2_i (rf_raddr2),
        .rdata1_o (rf_rdata1),
        .rdata2_o (rf_rdata2),
        .wen_i    (rf_wen),
        .waddr_i  (rf_waddr),
        .wdata_i  (rf_wdata)
    );

    rv_execute execute_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .dec_valid_i  (dec_valid),
        .dec_i        (dec_out),
        .ex_allowin_o (ex_allowin),
        .wb_allowin_i (wb_allowin),
        .ex_valid_o   (ex_valid),
        .ex_o         (ex_out)
    );

    rv_retire retire_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .ex_valid_i     (ex_valid),
        .ex_i           (ex_out),
        .wb_allowin_o   (wb_allowin),
        .retire_valid_o (retire_valid_o),
        .retire_o       (retire_o),
        .retire_ready_i (retire_ready_i),
        .rf_wen_o       (rf_wen),
        .rf_waddr_o     (rf_waddr),
        .rf_wdata_o     (rf_wdata)
    );

endmodule

//--- source/rv_retire.sv
module rv_retire (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              ex_valid_i,
    input  rv_pkg::ex_wb_t    ex_i,
    output logic              wb_allowin_o,
    output logic              retire_valid_o,
    output rv_pkg::ex_wb_t    retire_o,
    input  logic              retire_ready_i,
    output logic              rf_wen_o,
    output rv_pkg::reg_addr_t rf_waddr_o,
    output rv_pkg::xlen_t     rf_wdata_o
);

    logic leaving;

    assign leaving      = retire_valid_o && retire_ready_i;
    assign wb_allowin_o = !retire_valid_o || retire_ready_i;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            retire_valid_o <= 1'b0;
        end else if (wb_allowin_o) begin
            retire_valid_o <= ex_valid_i;
        end
    end

    // held until the consumer takes it
    always_ff @(posedge clk) begin
        if (ex_valid_i && wb_allowin_o)
            retire_o <= ex_i;
    end

    // commit on the same edge the result leaves
    assign rf_wen_o   = leaving && retire_o.wen;
    assign rf_waddr_o = retire_o.rd;
    assign rf_wdata_o = retire_o.data;

endmodule

//--- source/rv_execute.sv
module rv_execute (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           dec_valid_i,
    input  rv_pkg::id_ex_t dec_i,
    output logic           ex_allowin_o,
    input  logic           wb_allowin_i,
    output logic           ex_valid_o,
    output rv_pkg::ex_wb_t ex_o
);

    rv_pkg::xlen_t alu_res;
    logic [4:0]    shamt;

    assign shamt = dec_i.b[4:0];

    always_comb begin
        case (dec_i.alu_op)
            rv_pkg::ALU_ADD:    alu_res = dec_i.a + dec_i.b;
            rv_pkg::ALU_SUB:    alu_res = dec_i.a - dec_i.b;
            rv_pkg::ALU_AND:    alu_res = dec_i.a & dec_i.b;
            rv_pkg::ALU_OR:     alu_res = dec_i.a | dec_i.b;
            rv_pkg::ALU_XOR:    alu_res = dec_i.a ^ dec_i.b;
            rv_pkg::ALU_SLT:    alu_res = {31'b0, $signed(dec_i.a) < $signed(dec_i.b)};
            rv_pkg::ALU_SLTU:   alu_res = {31'b0, dec_i.a < dec_i.b};
            rv_pkg::ALU_SLL:    alu_res = dec_i.a << shamt;
            rv_pkg::ALU_SRL:    alu_res = dec_i.a >> shamt;
            rv_pkg::ALU_SRA:    alu_res = rv_pkg::xlen_t'($signed(dec_i.a) >>> shamt);
            rv_pkg::ALU_PASS_B: alu_res = dec_i.b;
            default:            alu_res = '0;
        endcase
    end

    // empty, or the held result moves on this cycle
    assign ex_allowin_o = !ex_valid_o || wb_allowin_i;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_valid_o <= 1'b0;
        end else if (ex_allowin_o) begin
            ex_valid_o <= dec_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (dec_valid_i && ex_allowin_o) begin
            ex_o.rd      <= dec_i.rd;
            ex_o.wen     <= dec_i.wen;
            ex_o.illegal <= dec_i.illegal;
            ex_o.data    <= alu_res;
        end
    end

endmodule

//--- source/rv_decode.sv
module rv_decode (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              inst_valid_i,
    input  rv_pkg::xlen_t     inst_i,
    output logic              inst_allowin_o,
    input  logic              ex_allowin_i,
    output logic              dec_valid_o,
    output rv_pkg::id_ex_t    dec_o,
    output rv_pkg::reg_addr_t rf_raddr1_o,
    output rv_pkg::reg_addr_t rf_raddr2_o,
    input  rv_pkg::xlen_t     rf_rdata1_i,
    input  rv_pkg::xlen_t     rf_rdata2_i,
    input  logic              ex_fwd_valid_i,
    input  rv_pkg::ex_wb_t    ex_fwd_i,
    input  logic              wb_fwd_valid_i,
    input  rv_pkg::ex_wb_t    wb_fwd_i
);

    rv_pkg::xlen_t     inst_q;
    rv_pkg::opcode_t   opcode;
    rv_pkg::funct3_t   funct3;
    rv_pkg::funct7_t   funct7;
    rv_pkg::reg_addr_t rs1;
    rv_pkg::reg_addr_t rs2;
    rv_pkg::reg_addr_t rd;
    rv_pkg::xlen_t     imm_i;
    rv_pkg::xlen_t     imm_u;
    rv_pkg::xlen_t     rs1_val;
    rv_pkg::xlen_t     rs2_val;
    rv_pkg::alu_op_e   alu_op;
    logic              is_op;
    logic              is_op_imm;
    logic              is_lui;
    logic              alt;
    logic              f7_ok;
    logic              legal;

    // youngest producer wins, register file last
    function automatic rv_pkg::xlen_t fwd_sel(
        input rv_pkg::reg_addr_t src,
        input rv_pkg::xlen_t     rf_data,
        input logic              ex_v,
        input rv_pkg::ex_wb_t    ex_r,
        input logic              wb_v,
        input rv_pkg::ex_wb_t    wb_r
    );
        rv_pkg::xlen_t val;
        val = rf_data;
        if (wb_v && wb_r.wen && wb_r.rd == src)
            val = wb_r.data;
        if (ex_v && ex_r.wen && ex_r.rd == src)
            val = ex_r.data;
        return val;
    endfunction

    assign inst_allowin_o = !dec_valid_o || ex_allowin_i;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dec_valid_o <= 1'b0;
        end else if (inst_allowin_o) begin
            dec_valid_o <= inst_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (inst_valid_i && inst_allowin_o)
            inst_q <= inst_i;
    end

    assign opcode    = inst_q[6:0];
    assign rd        = inst_q[11:7];
    assign funct3    = inst_q[14:12];
    assign rs1       = inst_q[19:15];
    assign rs2       = inst_q[24:20];
    assign funct7    = inst_q[31:25];
    assign imm_i     = {{20{inst_q[31]}}, inst_q[31:20]};
    assign imm_u     = {inst_q[31:12], 12'b0};
    assign is_op     = opcode == rv_pkg::OPC_OP;
    assign is_op_imm = opcode == rv_pkg::OPC_OP_IMM;
    assign is_lui    = opcode == rv_pkg::OPC_LUI;
    assign alt       = funct7 == rv_pkg::F7_ALT;

    always_comb begin
        case (funct3)
            3'b000:  alu_op = (is_op && alt) ? rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
            3'b001:  alu_op = rv_pkg::ALU_SLL;
            3'b010:  alu_op = rv_pkg::ALU_SLT;
            3'b011:  alu_op = rv_pkg::ALU_SLTU;
            3'b100:  alu_op = rv_pkg::ALU_XOR;
            3'b101:  alu_op = alt ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
            3'b110:  alu_op = rv_pkg::ALU_OR;
            default: alu_op = rv_pkg::ALU_AND;
        endcase
        if (is_lui)
            alu_op = rv_pkg::ALU_PASS_B;

        // funct7 only matters for register ops and immediate shifts
        if (is_op)
            f7_ok = funct7 == rv_pkg::F7_BASE || (alt && (funct3 == 3'b000 || funct3 == 3'b101));
        else if (funct3 == 3'b001)
            f7_ok = funct7 == rv_pkg::F7_BASE;
        else if (funct3 == 3'b101)
            f7_ok = funct7 == rv_pkg::F7_BASE || alt;
        else
            f7_ok = 1'b1;

        legal = is_lui || ((is_op || is_op_imm) && f7_ok);
    end

    assign rf_raddr1_o = rs1;
    assign rf_raddr2_o = rs2;

    assign rs1_val = fwd_sel(rs1, rf_rdata1_i, ex_fwd_valid_i, ex_fwd_i, wb_fwd_valid_i, wb_fwd_i);
    assign rs2_val = fwd_sel(rs2, rf_rdata2_i, ex_fwd_valid_i, ex_fwd_i, wb_fwd_valid_i, wb_fwd_i);

    always_comb begin
        dec_o.alu_op  = alu_op;
        dec_o.a       = rs1_val;
        dec_o.b       = is_op ? rs2_val : (is_lui ? imm_u : imm_i);
        dec_o.rd      = rd;
        // no write for x0 or unsupported words
        dec_o.wen     = legal && rd != '0;
        dec_o.illegal = !legal;
    end

endmodule

//--- source/rv_regfile.sv
module rv_regfile (
    input  logic              clk,
    input  logic              rst_n,
    input  rv_pkg::reg_addr_t raddr1_i,
    input  rv_pkg::reg_addr_t raddr2_i,
    output rv_pkg::xlen_t     rdata1_o,
    output rv_pkg::xlen_t     rdata2_o,
    input  logic              wen_i,
    input  rv_pkg::reg_addr_t waddr_i,
    input  rv_pkg::xlen_t     wdata_i
);

    // x0 has no storage
    rv_pkg::xlen_t regs [1:31];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wen_i) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    assign rdata1_o = (raddr1_i == '0) ? '0 : regs[raddr1_i];
    assign rdata2_o = (raddr2_i == '0) ? '0 : regs[raddr2_i];

endmodule

//--- source/rv_pkg.sv
package rv_pkg;

    localparam int XLEN = 32;

    typedef logic [XLEN-1:0] xlen_t;
    typedef logic [4:0]      reg_addr_t;
    typedef logic [6:0]      opcode_t;
    typedef logic [2:0]      funct3_t;
    typedef logic [6:0]      funct7_t;

    // major opcodes accepted by the core
    localparam opcode_t OPC_OP     = 7'b0110011;
    localparam opcode_t OPC_OP_IMM = 7'b0010011;
    localparam opcode_t OPC_LUI    = 7'b0110111;

    localparam funct7_t F7_BASE = 7'b0000000;
    // selects SUB and SRA
    localparam funct7_t F7_ALT  = 7'b0100000;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLTU,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_PASS_B
    } alu_op_e;

    // decode to execute
    typedef struct packed {
        alu_op_e   alu_op;
        xlen_t     a;
        xlen_t     b;
        reg_addr_t rd;
        logic      wen;
        logic      illegal;
    } id_ex_t;

    // execute result, also used for retire and forwarding
    typedef struct packed {
        reg_addr_t rd;
        logic      wen;
        logic      illegal;
        xlen_t     data;
    } ex_wb_t;

endpackage
